//--- cavlc_coef_pkg.sv
package cavlc_coef_pkg;

    // residual coefficients of one 4x4 block, signed.
    localparam int coef_width  = 15;
    localparam int block_size  = 16;
    localparam int index_width = $clog2(block_size); // scan position 0 to 15.

    typedef logic signed [coef_width-1:0] coef_t;

    // index 0 is the first coefficient in zig-zag scan order.
    typedef coef_t [block_size-1:0] coef_block_t;

    // what the trailing-ones logic needs to know about one coefficient.
    // A coefficient with neither is_zero nor is_one set has magnitude above one.
    typedef struct packed
    {
        logic is_zero;
        logic is_one;  // value is +1 or -1.
        logic neg;     // sign bit, 1 for negative.
    } coef_class_t;

    typedef coef_class_t [block_size-1:0] coef_class_vec_t;

endpackage

//--- cavlc_t1_pkg.sv
package cavlc_t1_pkg;

    // the standard codes at most three trailing ones per block.
    localparam int max_trailing_ones = 3;
    localparam int t1_count_width    = $clog2(max_trailing_ones + 1);

    typedef logic [t1_count_width-1:0] t1_count_t;

    // bit k is the sign of the k-th trailing one, counted from the block end.
    typedef logic [max_trailing_ones-1:0] t1_signs_t;

    typedef struct packed
    {
        t1_count_t count;
        t1_signs_t signs;
    } t1_result_t;

    // count takes one cycle, scan walks all sixteen positions, done presents signs.
    typedef enum logic [1:0]
    {
        st_idle,
        st_count,
        st_scan,
        st_done
    } scan_state_t;

endpackage

//--- coef_classifier.sv
`timescale 1ns/1ps

module coef_classifier
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  cavlc_coef_pkg::coef_block_t     coef_block,
    output cavlc_coef_pkg::coef_class_vec_t class_vec
);
    import cavlc_coef_pkg::*;

    coef_class_vec_t class_next;

    always_comb
    begin
        coef_t coef;

        coef = '0;
        for (int i = 0; i < block_size; i++)
        begin
            coef = coef_block[i];
            class_next[i].is_zero = (coef == '0);
            class_next[i].is_one  = (coef == coef_t'(1)) || (coef == coef_t'(-1));
            class_next[i].neg     = coef[coef_width-1];
        end
    end

    // the block is only needed as classes, so the capture register holds those.
    // The input may change freely once load has passed.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            class_vec <= '0;
        end
        else if (load)
        begin
            class_vec <= class_next;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the trailing-ones testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f sim.f --top-module tb_trailing_ones -o tb_trailing_ones

output=$(./obj_dir/tb_trailing_ones)
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1

//--- sim.f
cavlc_coef_pkg.sv
cavlc_t1_pkg.sv
coef_classifier.sv
t1_count_unit.sv
t1_scan_ctrl.sv
t1_sign_collector.sv
trailing_ones_top.sv
tb_trailing_ones.sv

//--- t1_count_unit.sv
`timescale 1ns/1ps

module t1_count_unit
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  cavlc_coef_pkg::coef_class_vec_t class_vec,
    output cavlc_t1_pkg::t1_count_t         t1_count
);
    import cavlc_coef_pkg::*;
    import cavlc_t1_pkg::*;

    logic                   big_found;
    logic [index_width-1:0] big_index;
    int                     ones_total;
    t1_count_t              count_next;

    // highest position holding a coefficient of magnitude above one.
    always_comb
    begin
        big_found = 1'b0;
        big_index = '0;
        for (int i = block_size - 1; i >= 0; i--)
        begin
            if (!big_found && !class_vec[i].is_zero && !class_vec[i].is_one)
            begin
                big_found = 1'b1;
                big_index = index_width'(i);
            end
        end
    end

    // zeros in between are skipped, so only the ones above that position count.
    always_comb
    begin
        ones_total = 0;
        for (int i = 0; i < block_size; i++)
        begin
            if (class_vec[i].is_one && (!big_found || (index_width'(i) > big_index)))
            begin
                ones_total = ones_total + 1;
            end
        end

        if (ones_total >= max_trailing_ones)
            count_next = t1_count_t'(max_trailing_ones);
        else
            count_next = t1_count_t'(ones_total);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            t1_count <= '0;
        end
        else if (load)
        begin
            t1_count <= count_next; // held until the next block.
        end
    end

endmodule

//--- t1_scan_ctrl.sv
`timescale 1ns/1ps

module t1_scan_ctrl
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 enable,
    output logic                                 load,
    output logic                                 count_load,
    output logic                                 scan_active,
    output logic [cavlc_coef_pkg::index_width-1:0] scan_index,
    output logic                                 count_valid,
    output logic                                 sign_valid
);
    import cavlc_coef_pkg::*;
    import cavlc_t1_pkg::*;

    scan_state_t state;
    scan_state_t state_next;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (enable)
                    state_next = st_count;
            end
            st_count:
            begin
                state_next = st_scan;
            end
            st_scan:
            begin
                if (scan_index == '0)
                    state_next = st_done; // position 0 is the last one sampled.
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    // a request is taken only while idle, anything else is ignored.
    assign load        = (state == st_idle) && enable;
    assign count_load  = (state == st_count); // classes are registered by now.
    assign scan_active = (state == st_scan);

    // the scan starts at the end of the block and walks towards index 0.
    always_ff @(posedge clk)
    begin
        if (rst)
            scan_index <= '0;
        else if (count_load)
            scan_index <= index_width'(block_size - 1);
        else if (scan_active)
            scan_index <= scan_index - index_width'(1);
    end

    // count_valid covers the whole encoding once the count is registered.
    // sign_valid pulses for the single cycle after done.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count_valid <= 1'b0;
            sign_valid  <= 1'b0;
        end
        else
        begin
            count_valid <= (state != st_idle);
            sign_valid  <= (state == st_done);
        end
    end

endmodule

//--- t1_sign_collector.sv
`timescale 1ns/1ps

module t1_sign_collector
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   scan_active,
    input  logic [cavlc_coef_pkg::index_width-1:0] scan_index,
    input  cavlc_coef_pkg::coef_class_vec_t        class_vec,
    input  cavlc_t1_pkg::t1_count_t                t1_count,
    output cavlc_t1_pkg::t1_signs_t                t1_signs
);
    import cavlc_coef_pkg::*;
    import cavlc_t1_pkg::*;

    t1_count_t   found;
    t1_count_t   found_base;
    t1_count_t   found_next;
    t1_signs_t   signs_base;
    t1_signs_t   signs_next;
    coef_class_t cur;
    logic        first_pos;

    assign cur       = class_vec[scan_index];
    assign first_pos = (scan_index == index_width'(block_size - 1));

    // the first position of a scan starts from an empty result.
    always_comb
    begin
        found_base = first_pos ? '0 : found;
        signs_base = first_pos ? '0 : t1_signs;
        found_next = found_base;
        signs_next = signs_base;

        // t1_count already stops at the first large coefficient.
        if (cur.is_one && (found_base < t1_count))
        begin
            signs_next[found_base] = cur.neg;
            found_next             = found_base + t1_count_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            found    <= '0;
            t1_signs <= '0;
        end
        else if (scan_active)
        begin
            found    <= found_next;
            t1_signs <= signs_next; // final after position 0, held until the next scan.
        end
    end

endmodule

//--- tb_trailing_ones.sv
`timescale 1ns/1ps

module tb_trailing_ones;
    import cavlc_coef_pkg::*;
    import cavlc_t1_pkg::*;

    localparam int num_encodings   = 206; // six directed encodings and 200 random ones.
    localparam int cycles_per_test = 25;
    localparam int watchdog_cycles = num_encodings * cycles_per_test + 300;
    localparam int lat_limit       = 40;

    logic        clk;
    logic        rst;
    logic        enable;
    coef_block_t coef_block;
    t1_count_t   t1_count;
    logic        count_valid;
    t1_signs_t   t1_signs;
    logic        sign_valid;

    int                         errors;
    integer                     seed;
    logic [max_trailing_ones:0] counts_seen;

    trailing_ones_top dut_i
    (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .coef_block  (coef_block),
        .t1_count    (t1_count),
        .count_valid (count_valid),
        .t1_signs    (t1_signs),
        .sign_valid  (sign_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("errors: %0d", errors + 1);
        $display("Regression failed");
        $finish;
    end

    function automatic t1_result_t make_result(input t1_count_t count, input t1_signs_t signs);
        t1_result_t r;
        r.count = count;
        r.signs = signs;
        return r;
    endfunction

    // walk down from the block end, skip zeros, stop at the first large value.
    task automatic model_trailing_ones(input coef_block_t blk, output t1_result_t exp);
        logic stop;
        exp  = '0;
        stop = 1'b0;
        for (int i = block_size - 1; i >= 0; i--)
        begin
            if (!stop && blk[i] != coef_t'(0))
            begin
                if (blk[i] == coef_t'(1) || blk[i] == coef_t'(-1))
                begin
                    if (exp.count < t1_count_t'(max_trailing_ones))
                    begin
                        exp.signs[exp.count] = (blk[i] < 0);
                        exp.count            = exp.count + 1'b1;
                    end
                end
                else
                begin
                    stop = 1'b1;
                end
            end
        end
    endtask

    task automatic check_value(input string name, input string what, input int expected,
                               input int actual);
        if (actual != expected)
        begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", name, what, expected, actual);
            errors++;
        end
    endtask

    // one encoding with latency checks, optionally poked with enable while busy.
    task automatic run_encoding(input string name, input coef_block_t blk,
                                input t1_result_t exp, input logic disturb);
        coef_block_t alt_block;
        int          lat;
        alt_block = ~blk;
        @(posedge clk);
        enable     <= 1'b1;
        coef_block <= blk;
        @(posedge clk);
        enable <= 1'b0; // this edge samples the request.
        lat = 0;
        @(negedge clk);
        while (!count_valid && lat < lat_limit)
        begin
            @(negedge clk);
            lat++;
        end
        if (!count_valid)
        begin
            $display("%s: count_valid never went high", name);
            errors++;
        end
        else
        begin
            check_value(name, "count latency", 1, lat);
            check_value(name, "count", int'(exp.count), int'(t1_count));
        end
        while (!sign_valid && lat < lat_limit)
        begin
            @(posedge clk);
            if (disturb && lat == 1)
            begin
                enable     <= 1'b1;
                coef_block <= alt_block;
            end
            else
            begin
                enable <= 1'b0;
            end
            @(negedge clk);
            lat++;
        end
        if (!sign_valid)
        begin
            $display("%s: sign_valid never went high", name);
            errors++;
        end
        else
        begin
            check_value(name, "sign latency", 18, lat);
            check_value(name, "count_valid during signs", 1, int'(count_valid));
            check_value(name, "count", int'(exp.count), int'(t1_count));
            check_value(name, "signs", int'(exp.signs), int'(t1_signs));
        end
        @(negedge clk);
        check_value(name, "sign_valid after pulse", 0, int'(sign_valid));
        check_value(name, "count_valid after pulse", 0, int'(count_valid));
    endtask

    task automatic test_reset_values();
        repeat (30)
        begin
            @(negedge clk);
            check_value("reset_values", "count_valid", 0, int'(count_valid));
            check_value("reset_values", "sign_valid", 0, int'(sign_valid));
            check_value("reset_values", "t1_count", 0, int'(t1_count));
            check_value("reset_values", "t1_signs", 0, int'(t1_signs));
        end
    endtask

    task automatic test_basic_block();
        coef_block_t blk;
        blk     = '0;
        blk[15] = coef_t'(-1);
        blk[13] = coef_t'(1);
        blk[12] = coef_t'(5);
        run_encoding("basic_block", blk, make_result(2'd2, 3'b001), 1'b0);
    endtask

    task automatic test_stop_cases();
        coef_block_t blk;
        blk     = '0;
        blk[15] = coef_t'(7);
        blk[14] = coef_t'(-1);
        blk[13] = coef_t'(1);
        run_encoding("large_at_end", blk, make_result(2'd0, 3'b000), 1'b0);
        blk = '0;
        run_encoding("all_zero", blk, make_result(2'd0, 3'b000), 1'b0);
        for (int i = 0; i < block_size; i++)
            blk[i] = coef_t'(1);
        blk[15] = coef_t'(-1);
        blk[14] = coef_t'(-1);
        blk[0]  = coef_t'(-1); // far beyond the cap of three.
        run_encoding("all_ones", blk, make_result(2'd3, 3'b011), 1'b0);
    endtask

    task automatic test_exact_timing();
        coef_block_t blk;
        blk     = '0;
        blk[10] = coef_t'(1);
        blk[3]  = coef_t'(-1);
        blk[0]  = coef_t'(-3);
        run_encoding("exact_timing", blk, make_result(2'd2, 3'b010), 1'b0);
    endtask

    task automatic test_busy_ignored();
        coef_block_t blk;
        blk     = '0;
        blk[15] = coef_t'(1);
        blk[14] = coef_t'(1);
        blk[13] = coef_t'(-1);
        blk[12] = coef_t'(2);
        run_encoding("busy_ignored", blk, make_result(2'd3, 3'b100), 1'b1);
    endtask

    // small values dominate so that runs of trailing ones are common.
    function automatic coef_t random_coef();
        int pick;
        pick = int'($unsigned($random(seed)) % 16);
        if (pick == 0)
            return coef_t'($random(seed));
        else if (pick <= 5)
            return coef_t'(0);
        else if (pick <= 8)
            return coef_t'(1);
        else if (pick <= 11)
            return coef_t'(-1);
        else if (pick <= 13)
            return coef_t'(2);
        else
            return coef_t'(-2);
    endfunction

    task automatic test_random_blocks();
        coef_block_t blk;
        t1_result_t  exp;
        for (int n = 0; n < 200; n++)
        begin
            for (int i = 0; i < block_size; i++)
                blk[i] = random_coef();
            model_trailing_ones(blk, exp);
            counts_seen[exp.count] = 1'b1;
            run_encoding("random_blocks", blk, exp, 1'b0);
        end
        if (counts_seen != '1)
        begin
            $display("random_blocks: not every count value was produced by the stimulus");
            errors++;
        end
    endtask

    initial
    begin
        rst         = 1'b1;
        enable      = 1'b0;
        coef_block  = '0;
        errors      = 0;
        seed        = 32'hca3aeb3c;
        counts_seen = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_reset_values();
        test_basic_block();
        test_stop_cases();
        test_exact_timing();
        test_busy_ignored();
        test_random_blocks();

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- trailing_ones_top.sv
`timescale 1ns/1ps

module trailing_ones_top
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    input  cavlc_coef_pkg::coef_block_t coef_block,
    output cavlc_t1_pkg::t1_count_t     t1_count,
    output logic                        count_valid,
    output cavlc_t1_pkg::t1_signs_t     t1_signs,
    output logic                        sign_valid
);
    import cavlc_coef_pkg::*;
    import cavlc_t1_pkg::*;

    logic                   load;
    logic                   count_load;
    logic                   scan_active;
    logic [index_width-1:0] scan_index;
    coef_class_vec_t        class_vec;
    t1_result_t             result;

    t1_scan_ctrl u_scan_ctrl
    (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .load        (load),
        .count_load  (count_load),
        .scan_active (scan_active),
        .scan_index  (scan_index),
        .count_valid (count_valid),
        .sign_valid  (sign_valid)
    );

    coef_classifier u_classifier
    (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .coef_block (coef_block),
        .class_vec  (class_vec)
    );

    // the count register loads one cycle after the classes.
    t1_count_unit u_count
    (
        .clk       (clk),
        .rst       (rst),
        .load      (count_load),
        .class_vec (class_vec),
        .t1_count  (result.count)
    );

    t1_sign_collector u_signs
    (
        .clk         (clk),
        .rst         (rst),
        .scan_active (scan_active),
        .scan_index  (scan_index),
        .class_vec   (class_vec),
        .t1_count    (result.count),
        .t1_signs    (result.signs)
    );

    assign t1_count = result.count;
    assign t1_signs = result.signs;

endmodule
